//--- design/riscv_lsu_pkg.sv
/*
  Data-side types shared by the load-store unit and the top level.
  Word, byte enable and byte offset widths, the access size and the
  LSU request state. Import with riscv_lsu_pkg::* in the module header.
*/
package riscv_lsu_pkg;

  localparam int WORD_W = 32;          // Data and address width
  localparam int BE_W   = WORD_W / 8;  // One enable per byte lane
  localparam int OFF_W  = 2;           // Byte offset within a word

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [OFF_W-1:0]  byte_off_t;

  // Access size, same coding as the ID stage hands to the LSU
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10   // 2'b11 also treated as byte
  } data_type_e;

  // One outstanding access at a time
  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } lsu_state_e;

endpackage

//--- design/riscv_csr_pkg.sv
/*
  Register map seen by the debug port.
  Counter addresses, debug address layout and the value returned for
  anything that is not mapped. Import with riscv_csr_pkg::*.
*/
package riscv_csr_pkg;

  import riscv_lsu_pkg::word_t;

  localparam int CSR_ADDR_W = 12;
  localparam int DBG_ADDR_W = 16;

  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [DBG_ADDR_W-1:0] dbg_addr_t;

  // Performance counters, load and store
  localparam csr_addr_t CSR_PCCR_LOAD  = 12'h782;
  localparam csr_addr_t CSR_PCCR_STORE = 12'h783;

  // Top nibble of a debug address, selects register space
  localparam logic [3:0] DBG_CSR_SPACE = 4'h7;

  // Read value of unmapped registers and of other debug spaces
  localparam word_t CSR_RDATA_NONE = '0;

endpackage

//--- design/riscv_csr_if.sv
`timescale 1ns/1ps
/*
  One register access per cycle, debug unit to performance counters.
  Read data comes back in the same cycle, decoded from csr_addr.
*/
interface riscv_csr_if import riscv_lsu_pkg::*, riscv_csr_pkg::*; ();

  logic      csr_access;  // Access strobe, qualifies writes
  logic      csr_we;
  csr_addr_t csr_addr;
  word_t     csr_wdata;
  word_t     csr_rdata;   // Combinational from csr_addr

  // Requester side
  modport dbg (output csr_access, csr_we, csr_addr, csr_wdata, input csr_rdata);

  // Register file side
  modport csr (input csr_access, csr_we, csr_addr, csr_wdata, output csr_rdata);

endinterface

//--- design/riscv_load_store_unit.sv
`timescale 1ns/1ps
/*
  Load-store unit. Takes a single-cycle request from execute, drives the
  data memory with req/gnt/rvalid and writes back one cycle after rvalid.
  Store data is rotated into its byte lanes, load data rotated back and
  sign- or zero-extended. Also flags granted loads and stores.
*/
module riscv_load_store_unit import riscv_lsu_pkg::*; (
  input  logic       clk,
  input  logic       arst_n_i,

  // Execute side
  input  logic       data_req_ex_i,
  input  logic       data_we_ex_i,
  input  data_type_e data_type_ex_i,
  input  logic       data_sign_ext_ex_i,
  input  word_t      operand_a_ex_i,
  input  word_t      operand_b_ex_i,
  input  word_t      data_wdata_ex_i,
  output logic       lsu_ready_ex_o,
  output word_t      data_rdata_ex_o,
  output logic       wb_valid_o,
  output logic       load_err_o,
  output logic       store_err_o,

  // Data memory
  output logic       data_req_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  output word_t      data_addr_o,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_wdata_o,
  input  word_t      data_rdata_i,
  input  logic       data_err_i,

  // Granted access events for the counters
  output logic       mem_load_o,
  output logic       mem_store_o
);

  lsu_state_e state_q, state_d;

  // Request registered at acceptance
  word_t      addr_q;
  logic       we_q;
  be_t        be_q;
  word_t      wdata_q;
  data_type_e type_q;      // Kept for load extension
  logic       sign_ext_q;
  byte_off_t  offset_q;

  word_t      addr_ex;
  byte_off_t  offset_ex;
  be_t        be_ex;
  word_t      wdata_ex;
  word_t      rdata_rot;
  word_t      rdata_ext;
  logic       accept;
  logic       resp;        // rvalid for our access

  //////////////////////////////////////////////////
  // Request side alignment
  //////////////////////////////////////////////////
  assign addr_ex   = operand_a_ex_i + operand_b_ex_i;
  assign offset_ex = addr_ex[1:0];
  assign accept    = data_req_ex_i & lsu_ready_ex_o;

  always_comb begin
    case (data_type_ex_i)
      SIZE_WORD: be_ex = 4'b1111;
      SIZE_HALF: be_ex = 4'b0011 << offset_ex;  // Two lanes from offset
      default:   be_ex = 4'b0001 << offset_ex;  // Single lane
    endcase
  end

  // Rotate left by whole bytes
  always_comb begin
    case (offset_ex)
      2'd0:    wdata_ex = data_wdata_ex_i;
      2'd1:    wdata_ex = {data_wdata_ex_i[23:0], data_wdata_ex_i[31:24]};
      2'd2:    wdata_ex = {data_wdata_ex_i[15:0], data_wdata_ex_i[31:16]};
      default: wdata_ex = {data_wdata_ex_i[7:0],  data_wdata_ex_i[31:8]};
    endcase
  end

  //////////////////////////////////////////////////
  // Response side, rotate back then extend
  //////////////////////////////////////////////////
  always_comb begin
    case (offset_q)
      2'd0:    rdata_rot = data_rdata_i;
      2'd1:    rdata_rot = {data_rdata_i[7:0],  data_rdata_i[31:8]};
      2'd2:    rdata_rot = {data_rdata_i[15:0], data_rdata_i[31:16]};
      default: rdata_rot = {data_rdata_i[23:0], data_rdata_i[31:24]};
    endcase
  end

  always_comb begin
    case (type_q)
      SIZE_WORD: rdata_ext = rdata_rot;
      SIZE_HALF: rdata_ext = {{16{sign_ext_q & rdata_rot[15]}}, rdata_rot[15:0]};
      default:   rdata_ext = {{24{sign_ext_q & rdata_rot[7]}}, rdata_rot[7:0]};
    endcase
  end

  //////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////
  assign resp = (state_q == WAIT_RVALID) & data_rvalid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:        if (accept)        state_d = WAIT_GNT;
      WAIT_GNT:    if (data_gnt_i)    state_d = WAIT_RVALID;  // Req drops next cycle
      WAIT_RVALID: if (data_rvalid_i) state_d = IDLE;
      default:                        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      wb_valid_o  <= 1'b0;
      load_err_o  <= 1'b0;
      store_err_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      wb_valid_o  <= resp;                        // Loads and stores alike
      load_err_o  <= resp & data_err_i & ~we_q;
      store_err_o <= resp & data_err_i &  we_q;
    end
  end

  // Payload, captured on acceptance and on response
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q     <= addr_ex;
      we_q       <= data_we_ex_i;
      be_q       <= be_ex;
      wdata_q    <= wdata_ex;
      type_q     <= data_type_ex_i;
      sign_ext_q <= data_sign_ext_ex_i;
      offset_q   <= offset_ex;
    end
    if (resp) data_rdata_ex_o <= rdata_ext;
  end

  assign lsu_ready_ex_o = (state_q == IDLE) & ~wb_valid_o;  // Wait out write-back

  assign data_req_o   = (state_q == WAIT_GNT);
  assign data_addr_o  = addr_q;
  assign data_we_o    = we_q;
  assign data_be_o    = be_q;
  assign data_wdata_o = wdata_q;

  assign mem_load_o  = data_req_o & data_gnt_i & ~we_q;
  assign mem_store_o = data_req_o & data_gnt_i &  we_q;

endmodule

//--- design/riscv_perf_counters.sv
`timescale 1ns/1ps
/*
  Load and store performance counters behind the register map.
  Each counts granted accesses of its kind; a register write to a
  counter in the same cycle takes priority over the increment.
*/
module riscv_perf_counters import riscv_lsu_pkg::*, riscv_csr_pkg::*; (
  input  logic     clk,
  input  logic     arst_n_i,

  input  logic     mem_load_i,   // Granted load this cycle
  input  logic     mem_store_i,  // Granted store this cycle

  riscv_csr_if.csr csr
);

  word_t pccr_load_q;
  word_t pccr_store_q;
  logic  csr_wr;
  logic  wr_load;
  logic  wr_store;

  //////////////////////////////////////////////////
  // Register access decode
  //////////////////////////////////////////////////
  assign csr_wr   = csr.csr_access & csr.csr_we;
  assign wr_load  = csr_wr & (csr.csr_addr == CSR_PCCR_LOAD);
  assign wr_store = csr_wr & (csr.csr_addr == CSR_PCCR_STORE);

  // Read mux, same cycle as the address
  always_comb begin
    case (csr.csr_addr)
      CSR_PCCR_LOAD:  csr.csr_rdata = pccr_load_q;
      CSR_PCCR_STORE: csr.csr_rdata = pccr_store_q;
      default:        csr.csr_rdata = CSR_RDATA_NONE;  // Unmapped
    endcase
  end

  //////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pccr_load_q  <= '0;
      pccr_store_q <= '0;
    end else begin
      if (wr_load)
        pccr_load_q <= csr.csr_wdata;       // Write wins
      else if (mem_load_i)
        pccr_load_q <= pccr_load_q + 1'b1;

      if (wr_store)
        pccr_store_q <= csr.csr_wdata;
      else if (mem_store_i)
        pccr_store_q <= pccr_store_q + 1'b1;
    end
  end

endmodule

//--- design/riscv_debug_unit.sv
`timescale 1ns/1ps
/*
  Debug port to register access bridge.
  A strobe into register space becomes one register access in the same
  cycle. Read data is registered and the ack follows one cycle later.
*/
module riscv_debug_unit import riscv_lsu_pkg::*, riscv_csr_pkg::*; (
  input  logic      clk,
  input  logic      arst_n_i,

  // Debug port
  input  logic      dbginf_strobe_i,  // One-cycle pulse
  input  logic      dbginf_we_i,
  input  dbg_addr_t dbginf_addr_i,
  input  word_t     dbginf_data_i,
  output logic      dbginf_ack_o,
  output word_t     dbginf_data_o,

  riscv_csr_if.dbg  csr
);

  logic csr_sel;    // Address falls in register space
  logic rd_strobe;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////
  assign csr_sel   = (dbginf_addr_i[15:12] == DBG_CSR_SPACE);
  assign rd_strobe = dbginf_strobe_i & ~dbginf_we_i;

  // Register access lasts only the strobe cycle
  assign csr.csr_access = dbginf_strobe_i & csr_sel;
  assign csr.csr_we     = dbginf_we_i;
  assign csr.csr_addr   = dbginf_addr_i[11:0];  // Low 12 bits are the register
  assign csr.csr_wdata  = dbginf_data_i;

  //////////////////////////////////////////////////
  // Ack and read data
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dbginf_ack_o <= 1'b0;
    end else begin
      dbginf_ack_o <= dbginf_strobe_i;  // Exactly one cycle later
    end
  end

  // Sampled in the strobe cycle, held until the next read
  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      dbginf_data_o <= csr_sel ? csr.csr_rdata : CSR_RDATA_NONE;
    end
  end

endmodule

//--- design/riscv_data_port.sv
`timescale 1ns/1ps
/*
  Data side of the core: load-store unit, load and store counters and
  the debug path to them. Plain ports only, instances and wires inside.
*/
module riscv_data_port import riscv_lsu_pkg::*, riscv_csr_pkg::*; (
  input  logic       clk,
  input  logic       arst_n_i,

  // Execute side
  input  logic       data_req_ex_i,
  input  logic       data_we_ex_i,
  input  data_type_e data_type_ex_i,
  input  logic       data_sign_ext_ex_i,
  input  word_t      operand_a_ex_i,
  input  word_t      operand_b_ex_i,
  input  word_t      data_wdata_ex_i,
  output logic       lsu_ready_ex_o,
  output word_t      data_rdata_ex_o,
  output logic       wb_valid_o,
  output logic       load_err_o,
  output logic       store_err_o,

  // Data memory
  output logic       data_req_o,
  output word_t      data_addr_o,
  output logic       data_we_o,
  output be_t        data_be_o,
  output word_t      data_wdata_o,
  input  logic       data_gnt_i,
  input  logic       data_rvalid_i,
  input  word_t      data_rdata_i,
  input  logic       data_err_i,

  // Debug port
  input  logic       dbginf_strobe_i,
  input  logic       dbginf_we_i,
  input  dbg_addr_t  dbginf_addr_i,
  input  word_t      dbginf_data_i,
  output logic       dbginf_ack_o,
  output word_t      dbginf_data_o
);

  logic mem_load;   // Granted load
  logic mem_store;  // Granted store

  riscv_csr_if csr_if ();

  ////////////////////////////////////////////////////
  // Load-store unit
  ////////////////////////////////////////////////////
  riscv_load_store_unit load_store_unit_i (
    .clk                ( clk                ),
    .arst_n_i           ( arst_n_i           ),
    .data_req_ex_i      ( data_req_ex_i      ),
    .data_we_ex_i       ( data_we_ex_i       ),
    .data_type_ex_i     ( data_type_ex_i     ),
    .data_sign_ext_ex_i ( data_sign_ext_ex_i ),
    .operand_a_ex_i     ( operand_a_ex_i     ),
    .operand_b_ex_i     ( operand_b_ex_i     ),
    .data_wdata_ex_i    ( data_wdata_ex_i    ),
    .lsu_ready_ex_o     ( lsu_ready_ex_o     ),
    .data_rdata_ex_o    ( data_rdata_ex_o    ),
    .wb_valid_o         ( wb_valid_o         ),
    .load_err_o         ( load_err_o         ),
    .store_err_o        ( store_err_o        ),
    .data_req_o         ( data_req_o         ),
    .data_gnt_i         ( data_gnt_i         ),
    .data_rvalid_i      ( data_rvalid_i      ),
    .data_addr_o        ( data_addr_o        ),
    .data_we_o          ( data_we_o          ),
    .data_be_o          ( data_be_o          ),
    .data_wdata_o       ( data_wdata_o       ),
    .data_rdata_i       ( data_rdata_i       ),
    .data_err_i         ( data_err_i         ),
    .mem_load_o         ( mem_load           ),  // To counters
    .mem_store_o        ( mem_store          )
  );

  ////////////////////////////////////////////////////
  // Counters and debug access
  ////////////////////////////////////////////////////
  riscv_perf_counters perf_counters_i (
    .clk         ( clk       ),
    .arst_n_i    ( arst_n_i  ),
    .mem_load_i  ( mem_load  ),
    .mem_store_i ( mem_store ),
    .csr         ( csr_if    )
  );

  riscv_debug_unit debug_unit_i (
    .clk             ( clk             ),
    .arst_n_i        ( arst_n_i        ),
    .dbginf_strobe_i ( dbginf_strobe_i ),
    .dbginf_we_i     ( dbginf_we_i     ),
    .dbginf_addr_i   ( dbginf_addr_i   ),
    .dbginf_data_i   ( dbginf_data_i   ),
    .dbginf_ack_o    ( dbginf_ack_o    ),
    .dbginf_data_o   ( dbginf_data_o   ),
    .csr             ( csr_if          )   // Register access master
  );

endmodule

//--- sim/riscv_data_port_assertions.sv
`timescale 1ns/1ps
/*
  Protocol assertions bound into the data port. Memory request held with
  a stable address until grant, debug ack one cycle after each strobe,
  and natural alignment of every accepted access.
*/
module riscv_data_port_assertions import riscv_lsu_pkg::*; (
  input logic       clk,
  input logic       arst_n_i,
  input logic       req_i,
  input logic       gnt_i,
  input word_t      addr_i,
  input logic       strobe_i,
  input logic       ack_i,
  input logic       accept_i,   // Execute request taken this cycle
  input data_type_e type_i,
  input word_t      op_a_i,
  input word_t      op_b_i
);

  word_t ex_addr;
  logic  misaligned;

  assign ex_addr    = op_a_i + op_b_i;
  assign misaligned = (type_i == SIZE_WORD && ex_addr[1:0] != 2'b00) ||
                      (type_i == SIZE_HALF && ex_addr[0]);

  req_held_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    req_i && !gnt_i |=> req_i && $stable(addr_i))
    else $error("Memory request dropped or moved before grant");

  ack_after_strobe_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    strobe_i |=> ack_i)
    else $error("No debug ack one cycle after the strobe");

  ack_only_after_strobe_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    !strobe_i |=> !ack_i)
    else $error("Debug ack without a strobe in the cycle before");

  aligned_a: assert property (@(posedge clk) disable iff (!arst_n_i)
    accept_i |-> !misaligned)
    else $error("Accepted access is not naturally aligned");

endmodule

bind riscv_data_port riscv_data_port_assertions data_port_assertions_i (
  .clk      ( clk                            ),
  .arst_n_i ( arst_n_i                       ),
  .req_i    ( data_req_o                     ),
  .gnt_i    ( data_gnt_i                     ),
  .addr_i   ( data_addr_o                    ),
  .strobe_i ( dbginf_strobe_i                ),
  .ack_i    ( dbginf_ack_o                   ),
  .accept_i ( data_req_ex_i & lsu_ready_ex_o ),
  .type_i   ( data_type_ex_i                 ),
  .op_a_i   ( operand_a_ex_i                 ),
  .op_b_i   ( operand_b_ex_i                 )
);

//--- sim/tb_riscv_data_port.sv
`timescale 1ns/1ps
/*
  Testbench for the data port. Issues aligned loads and stores from the
  execute side, answers them from a small memory model with random grant
  and rvalid latency, and reads and writes the counters over the debug
  port. Every write-back and every debug ack is checked in one process.
*/
module tb_riscv_data_port import riscv_lsu_pkg::*, riscv_csr_pkg::*; ();

  localparam int    TIMEOUT   = 64;            // Cycles allowed for any wait
  localparam int    MEM_WORDS = 16;
  localparam word_t MEM_BASE  = 32'h1000_0000;

  // Expected results from the reference function
  typedef struct packed {
    be_t   be;
    word_t wdata;   // Store data in its byte lanes
    word_t rdata;   // Extended load value
  } ref_t;

  typedef struct packed {
    logic  is_load;
    logic  err;
    word_t rdata;
  } wb_exp_t;

  typedef struct packed {
    logic  is_read;
    word_t rdata;
  } dbg_exp_t;

  logic       clk;
  logic       arst_n_i;
  logic       data_req_ex_i;
  logic       data_we_ex_i;
  data_type_e data_type_ex_i;
  logic       data_sign_ext_ex_i;
  word_t      operand_a_ex_i;
  word_t      operand_b_ex_i;
  word_t      data_wdata_ex_i;
  logic       lsu_ready_ex_o;
  word_t      data_rdata_ex_o;
  logic       wb_valid_o;
  logic       load_err_o;
  logic       store_err_o;
  logic       data_req_o;
  word_t      data_addr_o;
  logic       data_we_o;
  be_t        data_be_o;
  word_t      data_wdata_o;
  logic       data_gnt_i;
  logic       data_rvalid_i;
  word_t      data_rdata_i;
  logic       data_err_i;
  logic       dbginf_strobe_i;
  logic       dbginf_we_i;
  dbg_addr_t  dbginf_addr_i;
  word_t      dbginf_data_i;
  logic       dbginf_ack_o;
  word_t      dbginf_data_o;

  integer     seed = 32'h9d9ea705;
  word_t      mem [MEM_WORDS];       // Memory model
  word_t      cnt_load;              // Own count of granted loads
  word_t      cnt_store;
  wb_exp_t    exp_wb_q [$];
  dbg_exp_t   exp_dbg_q [$];

  riscv_data_port riscv_data_port_i (.*);

  always begin
    clk = 1'b0;
    #4;
    clk = 1'b1;
    #4;
  end

  //////////////////////////////////////////////////
  // Reference model and reporting
  //////////////////////////////////////////////////
  function automatic ref_t ref_access(data_type_e size, byte_off_t off, logic sign,
                                      word_t wdata, word_t mem_word);
    ref_t  r;
    word_t val;
    int    nbytes;
    int    lane;
    int    i;
    nbytes  = (size == SIZE_WORD) ? 4 : (size == SIZE_HALF) ? 2 : 1;
    r.be    = '0;
    r.wdata = '0;
    val     = '0;
    for (i = 0; i < 4; i++) begin
      lane = (i + off) % 4;                  // Byte i lands in this lane
      r.wdata[8*lane +: 8] = wdata[8*i +: 8];
      if (i < nbytes) begin
        r.be[lane]      = 1'b1;
        val[8*i +: 8]   = mem_word[8*lane +: 8];
      end
    end
    if (sign && nbytes < 4 && val[8*nbytes-1])
      for (i = nbytes; i < 4; i++) val[8*i +: 8] = 8'hff;  // Sign fill
    r.rdata = val;
    return r;
  endfunction

  task automatic stop_run(string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_value(string name, word_t got, word_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR %s = 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  // Checker samples away from the rising edge
  always @(negedge clk) begin : compare
    wb_exp_t  w;
    dbg_exp_t d;
    if (arst_n_i === 1'b1 && wb_valid_o === 1'b1) begin
      if (exp_wb_q.size() == 0) begin
        stop_run("Write-back pulse with no access outstanding");
      end else begin
        w = exp_wb_q.pop_front();
        compare_value("load_err_o", load_err_o, w.is_load & w.err);
        compare_value("store_err_o", store_err_o, ~w.is_load & w.err);
        if (w.is_load) compare_value("data_rdata_ex_o", data_rdata_ex_o, w.rdata);
      end
    end
    if (arst_n_i === 1'b1 && dbginf_ack_o === 1'b1) begin
      if (exp_dbg_q.size() == 0) begin
        stop_run("Debug ack with no strobe outstanding");
      end else begin
        d = exp_dbg_q.pop_front();
        if (d.is_read) compare_value("dbginf_data_o", dbginf_data_o, d.rdata);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #1;                                      // Drive just after the edge
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (lsu_ready_ex_o !== 1'b1) begin
      if (n == TIMEOUT) stop_run("Timeout waiting for lsu_ready_ex_o");
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_wb_checked();
    int n;
    n = 0;
    while (exp_wb_q.size() != 0) begin
      if (n == TIMEOUT) stop_run("Timeout waiting for the write-back check");
      next_cycle();
      n++;
    end
  endtask

  // One execute-side access with the memory side answered here as well
  task automatic run_access(logic we, data_type_e size, logic sign, logic err);
    byte_off_t off;
    word_t     addr;
    word_t     wdata;
    ref_t      exp;
    wb_exp_t   wb;
    int        idx;
    int        n;
    int        i;
    idx = $unsigned($random(seed)) % MEM_WORDS;
    off = byte_off_t'($random(seed));
    if (size == SIZE_WORD) off = 2'd0;       // Natural alignment only
    else if (size == SIZE_HALF) off[0] = 1'b0;
    addr  = MEM_BASE + idx * 4 + off;
    wdata = $random(seed);
    exp   = ref_access(size, off, sign, wdata, mem[idx]);
    wait_ready();
    data_req_ex_i      = 1'b1;
    data_we_ex_i       = we;
    data_type_ex_i     = size;
    data_sign_ext_ex_i = sign;
    operand_a_ex_i     = $random(seed);
    operand_b_ex_i     = addr - operand_a_ex_i;
    data_wdata_ex_i    = wdata;
    next_cycle();
    data_req_ex_i = 1'b0;
    compare_value("data_req_o", data_req_o, 1);
    compare_value("lsu_ready_ex_o", lsu_ready_ex_o, 0);  // Busy with this access
    compare_value("data_addr_o", data_addr_o, addr);
    compare_value("data_we_o", data_we_o, we);
    compare_value("data_be_o", data_be_o, exp.be);
    if (we) compare_value("data_wdata_o", data_wdata_o, exp.wdata);
    n = $unsigned($random(seed)) % 4;        // Grant latency 0 to 3
    repeat (n) begin
      next_cycle();
      compare_value("data_req_o", data_req_o, 1);     // Held until grant
      compare_value("data_addr_o", data_addr_o, addr);
    end
    data_gnt_i = 1'b1;
    if (we) cnt_store++;
    else cnt_load++;
    next_cycle();
    data_gnt_i = 1'b0;
    compare_value("data_req_o", data_req_o, 0);
    if (we && !err)
      for (i = 0; i < 4; i++)
        if (exp.be[i]) mem[idx][8*i +: 8] = exp.wdata[8*i +: 8];
    exp = ref_access(size, off, sign, wdata, mem[idx]);
    n = $unsigned($random(seed)) % 3;        // Rvalid 1 to 3 after grant
    repeat (n) next_cycle();
    data_rvalid_i = 1'b1;
    data_rdata_i  = mem[idx];
    data_err_i    = err;
    wb.is_load = ~we;
    wb.err     = err;
    wb.rdata   = exp.rdata;
    exp_wb_q.push_back(wb);
    next_cycle();
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = $random(seed);           // Garbage off the response
    compare_value("wb_valid_o", wb_valid_o, 1);
    compare_value("lsu_ready_ex_o", lsu_ready_ex_o, 0);  // No accept in write-back
    wait_wb_checked();
  endtask

  task automatic debug_access(logic we, dbg_addr_t addr, word_t wdata, word_t exp_rdata);
    dbg_exp_t d;
    dbginf_strobe_i = 1'b1;
    dbginf_we_i     = we;
    dbginf_addr_i   = addr;
    dbginf_data_i   = wdata;
    d.is_read = ~we;
    d.rdata   = exp_rdata;
    exp_dbg_q.push_back(d);
    next_cycle();
    dbginf_strobe_i = 1'b0;
    compare_value("dbginf_ack_o", dbginf_ack_o, 1);  // One cycle after strobe
    next_cycle();
    compare_value("dbginf_ack_o", dbginf_ack_o, 0);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    int k;
    arst_n_i           = 1'b0;
    data_req_ex_i      = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = SIZE_WORD;
    data_sign_ext_ex_i = 1'b0;
    operand_a_ex_i     = '0;
    operand_b_ex_i     = '0;
    data_wdata_ex_i    = '0;
    data_gnt_i         = 1'b0;
    data_rvalid_i      = 1'b0;
    data_rdata_i       = '0;
    data_err_i         = 1'b0;
    dbginf_strobe_i    = 1'b0;
    dbginf_we_i        = 1'b0;
    dbginf_addr_i      = '0;
    dbginf_data_i      = '0;
    cnt_load           = '0;
    cnt_store          = '0;
    for (k = 0; k < MEM_WORDS; k++)
      mem[k] = (MEM_BASE + 4 * k) * 32'h9e37_79b9;  // Pattern from byte address
    repeat (3) @(posedge clk);
    #1;
    arst_n_i = 1'b1;

    // Reset state
    compare_value("data_req_o", data_req_o, 0);
    compare_value("wb_valid_o", wb_valid_o, 0);
    compare_value("dbginf_ack_o", dbginf_ack_o, 0);
    compare_value("lsu_ready_ex_o", lsu_ready_ex_o, 1);
    debug_access(1'b0, {DBG_CSR_SPACE, CSR_PCCR_LOAD}, '0, '0);
    debug_access(1'b0, {DBG_CSR_SPACE, CSR_PCCR_STORE}, '0, '0);

    for (k = 0; k < 12; k++)
      run_access(1'b1, data_type_e'(k % 3), 1'b0, 1'b0);
    for (k = 0; k < 18; k++)
      run_access(1'b0, data_type_e'(k % 3), k[0] ^ k[1], 1'b0);  // Signed and unsigned
    run_access(1'b1, SIZE_HALF, 1'b0, 1'b1);  // Error responses
    run_access(1'b0, SIZE_BYTE, 1'b1, 1'b1);

    // Counters against own counts then overwrite and keep counting
    debug_access(1'b0, {DBG_CSR_SPACE, CSR_PCCR_LOAD}, '0, cnt_load);
    debug_access(1'b0, {DBG_CSR_SPACE, CSR_PCCR_STORE}, '0, cnt_store);
    cnt_load  = 32'h0000_1000;
    cnt_store = 32'hffff_fffe;                // Wraps after two stores
    debug_access(1'b1, {DBG_CSR_SPACE, CSR_PCCR_LOAD}, cnt_load, '0);
    debug_access(1'b1, {DBG_CSR_SPACE, CSR_PCCR_STORE}, cnt_store, '0);
    for (k = 0; k < 6; k++)
      run_access(k[0], data_type_e'($unsigned($random(seed)) % 3), 1'b1, 1'b0);
    debug_access(1'b0, {DBG_CSR_SPACE, CSR_PCCR_LOAD}, '0, cnt_load);
    debug_access(1'b0, {DBG_CSR_SPACE, CSR_PCCR_STORE}, '0, cnt_store);

    // Outside register space and unmapped registers
    debug_access(1'b0, {4'h3, CSR_PCCR_LOAD}, '0, '0);
    debug_access(1'b0, {DBG_CSR_SPACE, 12'h780}, '0, '0);
    debug_access(1'b1, {4'h2, CSR_PCCR_STORE}, 32'h1234_5678, '0);
    debug_access(1'b0, {DBG_CSR_SPACE, CSR_PCCR_STORE}, '0, cnt_store);

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- all.f
design/riscv_lsu_pkg.sv
design/riscv_csr_pkg.sv
design/riscv_csr_if.sv
design/riscv_load_store_unit.sv
design/riscv_perf_counters.sv
design/riscv_debug_unit.sv
design/riscv_data_port.sv
sim/riscv_data_port_assertions.sv
sim/tb_riscv_data_port.sv

//--- run.sh
#!/usr/bin/env bash
# Build the data port testbench with Verilator, run it, and check the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_riscv_data_port --Mdir obj_dir -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
